// ==== gray_codec_top.f ====
common/gray_codec_pkg.sv
common/codec_step_if.sv
hw/codec/g2b_chain.sv
hw/codec/slice_datapath.sv
hw/codec/codec_ctrl.sv
hw/gray_codec_top.sv
test/gray_codec_assert.sv
test/gray_codec_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := gray_codec_tb
FILELIST   := gray_codec_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/gray_codec_tb.sv ====
`timescale 1ns/1ps

module gray_codec_tb
    import gray_codec_pkg::*;
;

    localparam int NUM_TESTS  = 24;
    localparam int WAIT_LIMIT = 4 * ROUNDS;

    logic        clk;
    logic        rst;
    codec_mode_t mode;
    logic        start;
    data_t       data_in;
    data_t       data_out;
    logic        data_out_valid;
    logic        busy;

    // stimulus table, one row per conversion
    codec_mode_t tbl_mode    [NUM_TESTS];
    data_t       tbl_data    [NUM_TESTS];
    data_t       tbl_exp     [NUM_TESTS];
    logic        tbl_chain   [NUM_TESTS];  // data_in is the previous result
    logic        tbl_disturb [NUM_TESTS];  // extra start and mode flip mid run

    integer seed;
    int     cycle_cnt;
    int     pass_count;
    int     fail_count;
    int     num_entries;
    data_t  last_out;

    gray_codec_top u_gray_codec_top (
        .clk            (clk),
        .rst            (rst),
        .mode           (mode),
        .start          (start),
        .data_in        (data_in),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // reference rules, whole word at once
    function automatic data_t b2g_ref(input data_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic data_t g2b_ref(input data_t gray);
        data_t bin;
        bin[DATA_W-1] = gray[DATA_W-1];
        for (int i = DATA_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    function automatic data_t random_word();
        data_t w;
        for (int i = 0; i < DATA_W / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    task automatic add_entry(input codec_mode_t m, input data_t d, input data_t e,
                             input logic chain, input logic disturb);
        tbl_mode[num_entries]    = m;
        tbl_data[num_entries]    = d;
        tbl_exp[num_entries]     = e;
        tbl_chain[num_entries]   = chain;
        tbl_disturb[num_entries] = disturb;
        num_entries++;
    endtask

    task automatic fill_table();
        data_t r;
        num_entries = 0;
        add_entry(MODE_B2G, 128'h0, 128'h0, 1'b0, 1'b0);
        add_entry(MODE_B2G, 128'hffffffff_ffffffff_ffffffff_ffffffff,
                  128'h80000000_00000000_00000000_00000000, 1'b0, 1'b0);
        add_entry(MODE_B2G, 128'h55555555_55555555_55555555_55555555,
                  128'h7fffffff_ffffffff_ffffffff_ffffffff, 1'b0, 1'b0);
        add_entry(MODE_B2G, 128'h80000000_00000000_00000000_00000000,
                  128'hc0000000_00000000_00000000_00000000, 1'b0, 1'b0);
        add_entry(MODE_B2G, 128'h1, 128'h1, 1'b0, 1'b0);
        add_entry(MODE_B2G, 128'h100, 128'h180, 1'b0, 1'b0);  // bit 8 sees bit 7 flip
        add_entry(MODE_G2B, 128'h0, 128'h0, 1'b0, 1'b0);
        // carry has to ripple through every slice
        add_entry(MODE_G2B, 128'h80000000_00000000_00000000_00000000,
                  128'hffffffff_ffffffff_ffffffff_ffffffff, 1'b0, 1'b0);
        add_entry(MODE_G2B, 128'hffffffff_ffffffff_ffffffff_ffffffff,
                  128'haaaaaaaa_aaaaaaaa_aaaaaaaa_aaaaaaaa, 1'b0, 1'b0);
        add_entry(MODE_G2B, 128'hc0000000_00000000_00000000_00000000,
                  128'h80000000_00000000_00000000_00000000, 1'b0, 1'b0);
        add_entry(MODE_G2B, 128'h1, 128'h1, 1'b0, 1'b0);
        add_entry(MODE_G2B, 128'h10000, 128'h1ffff, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            r = random_word();
            add_entry(MODE_B2G, r, b2g_ref(r), 1'b0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            r = random_word();
            add_entry(MODE_G2B, r, g2b_ref(r), 1'b0, 1'b0);
        end
        // round trip, the second row feeds the gray result back in
        r = random_word();
        add_entry(MODE_B2G, r, b2g_ref(r), 1'b0, 1'b0);
        add_entry(MODE_G2B, 128'h0, r, 1'b1, 1'b0);
        r = random_word();
        add_entry(MODE_B2G, r, b2g_ref(r), 1'b0, 1'b1);
        r = random_word();
        add_entry(MODE_G2B, r, g2b_ref(r), 1'b0, 1'b1);
    endtask

    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    task automatic check_idle(inout logic ok);
        if (busy !== 1'b0) begin
            report_mismatch("busy", data_t'(1'b0), data_t'(busy));
            ok = 1'b0;
        end
        if (data_out_valid !== 1'b0) begin
            report_mismatch("data_out_valid", data_t'(1'b0), data_t'(data_out_valid));
            ok = 1'b0;
        end
        if (data_out !== '0) begin
            report_mismatch("data_out", '0, data_out);
            ok = 1'b0;
        end
    endtask

    task automatic wait_for_idle(output logic done);
        int n;
        done = 1'b0;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (busy === 1'b0) begin
                done = 1'b1;
            end
            n++;
        end
    endtask

    task automatic wait_for_valid(output logic done);
        int n;
        done = 1'b0;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (data_out_valid === 1'b1) begin
                done = 1'b1;
            end
            n++;
        end
    endtask

    // start while busy, with the other mode and inverted data
    task automatic disturb_run(input data_t stim);
        repeat (4) @(posedge clk);
        start   <= 1'b1;
        mode    <= (mode == MODE_B2G) ? MODE_G2B : MODE_B2G;
        data_in <= ~stim;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // after a disturbed run nothing else may come out
    task automatic check_quiet(input data_t exp, inout logic ok);
        for (int i = 0; i < ROUNDS + 4; i++) begin
            @(negedge clk);
            if (data_out_valid !== 1'b0 || busy !== 1'b0) begin
                $display("ignored start at %0t ns produced another conversion", $time);
                ok = 1'b0;
            end
            if (data_out !== exp) begin
                report_mismatch("data_out", exp, data_out);
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_reset();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_idle(ok);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle(ok);  // first cycle out of reset
        $display("test reset: %s", ok ? "pass" : "FAIL");
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    task automatic run_test(input int idx);
        data_t stim;
        logic  ok;
        logic  done;
        int    start_cyc;
        int    latency;
        string label;
        ok = 1'b1;
        stim = tbl_chain[idx] ? last_out : tbl_data[idx];
        label = (tbl_mode[idx] == MODE_B2G) ? "b2g" : "g2b";
        wait_for_idle(done);
        if (!done) begin
            $display("test %0d: DUT stayed busy, no start could be issued", idx);
            ok = 1'b0;
        end
        @(posedge clk);
        mode    <= tbl_mode[idx];
        data_in <= stim;
        start   <= 1'b1;
        @(posedge clk);  // start sampled here
        start <= 1'b0;
        @(negedge clk);
        start_cyc = cycle_cnt;
        if (busy !== 1'b1) begin
            report_mismatch("busy", data_t'(1'b1), data_t'(busy));
            ok = 1'b0;
        end
        if (tbl_disturb[idx]) begin
            disturb_run(stim);
        end
        wait_for_valid(done);
        if (!done) begin
            $display("test %0d: no data_out_valid pulse within %0d cycles", idx, WAIT_LIMIT);
            ok = 1'b0;
        end else begin
            latency = cycle_cnt - start_cyc;
            if (latency != ROUNDS) begin
                $display("Error at %0t ns: latency expected %0d, got %0d",
                         $time, ROUNDS, latency);
                ok = 1'b0;
            end
            if (data_out !== tbl_exp[idx]) begin
                report_mismatch("data_out", tbl_exp[idx], data_out);
                ok = 1'b0;
            end
            if (busy !== 1'b0) begin
                report_mismatch("busy", data_t'(1'b0), data_t'(busy));
                ok = 1'b0;
            end
            last_out = data_out;
            @(negedge clk);
            if (data_out_valid !== 1'b0) begin
                report_mismatch("data_out_valid", data_t'(1'b0), data_t'(data_out_valid));
                ok = 1'b0;
            end
            if (tbl_disturb[idx]) begin
                check_quiet(tbl_exp[idx], ok);
            end
        end
        $display("test %0d %s: %s", idx, label, ok ? "pass" : "FAIL");
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        seed       = 32'h1668;
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        mode       = MODE_B2G;
        data_in    = '0;
        cycle_cnt  = 0;
        pass_count = 0;
        fail_count = 0;
        last_out   = '0;
        fill_table();
        check_reset();
        for (int t = 0; t < num_entries; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/gray_codec_assert.sv ====
`timescale 1ns/1ps

module gray_codec_assert
    import gray_codec_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic data_out_valid
);

    // result strobe is a single cycle
    valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
        data_out_valid |=> !data_out_valid)
        else $error("data_out_valid high for more than one cycle");

    // a full conversion of busy cycles sits right before each result
    valid_after_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(data_out_valid) |-> $past(busy, 1) && $past(busy, ROUNDS)
            && !$past(busy, ROUNDS + 1))
        else $error("data_out_valid not preceded by %0d busy cycles", ROUNDS);

    busy_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start");

endmodule

bind gray_codec_top gray_codec_assert u_gray_codec_assert (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .busy           (busy),
    .data_out_valid (data_out_valid)
);

// ==== hw/gray_codec_top.sv ====
`timescale 1ns/1ps

// sequential 128-bit binary/gray converter, one 8-bit slice per clock
module gray_codec_top
    import gray_codec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  codec_mode_t mode,
    input  logic        start,
    input  data_t       data_in,
    output data_t       data_out,
    output logic        data_out_valid,
    output logic        busy
);

    codec_step_if u_step_if ();

    // sequencer: start handling, round count, captured mode
    codec_ctrl u_codec_ctrl (
        .clk   (clk),
        .rst   (rst),
        .mode  (mode),
        .start (start),
        .busy  (busy),
        .step  (u_step_if.ctrl)
    );

    // working register, slice xor logic and result register
    slice_datapath u_slice_datapath (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .step           (u_step_if.dp),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

endmodule

// ==== hw/codec/codec_ctrl.sv ====
`timescale 1ns/1ps

module codec_ctrl
    import gray_codec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  codec_mode_t  mode,
    input  logic         start,
    output logic         busy,
    codec_step_if.ctrl   step
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    round_t      round_q;
    codec_mode_t mode_q;
    logic        accept;
    logic        final_round;

    // start only counts while nothing is running
    assign accept      = (state_q == ST_IDLE) && start;
    assign final_round = (round_q == round_t'(ROUNDS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                if (final_round) begin
                    state_d = ST_IDLE;  // word finished at this edge
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // round counter and the mode latched for this conversion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            round_q <= '0;
            mode_q  <= MODE_B2G;
        end else if (accept) begin
            round_q <= '0;
            mode_q  <= mode;  // later changes on the pin are ignored
        end else if (state_q == ST_RUN) begin
            round_q <= round_q + 1'b1;  // wraps back to zero after the last round
        end
    end

    assign busy = (state_q == ST_RUN);

    assign step.load  = accept;  // same edge that samples start
    assign step.step  = (state_q == ST_RUN);
    assign step.round = round_q;
    assign step.mode  = mode_q;
    assign step.last  = (state_q == ST_RUN) && final_round;

endmodule

// ==== hw/codec/slice_datapath.sv ====
`timescale 1ns/1ps

module slice_datapath
    import gray_codec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  data_t       data_in,
    codec_step_if.dp    step,
    output data_t       data_out,
    output logic        data_out_valid
);

    data_t       work_q;      // word being converted in place
    data_t       work_next;   // work_q with the current slice replaced
    data_t       upper_bits;  // each bit's left neighbour, zero above the top
    round_t      slice_idx;
    int unsigned slice_base;
    slice_t      cur_slice;
    slice_t      nbr_slice;
    slice_t      b2g_slice;
    slice_t      g2b_slice;
    slice_t      new_slice;
    logic        g2b_advance;

    // b2g walks upwards from slice 0, g2b walks down from the top slice
    always_comb begin
        if (step.mode == MODE_B2G) begin
            slice_idx = step.round;
        end else begin
            slice_idx = round_t'(ROUNDS - 1) - step.round;
        end
    end

    assign slice_base = slice_idx * SLICE_W;
    assign cur_slice  = work_q[slice_base +: SLICE_W];

    // slices above are still unconverted in b2g, so the neighbour is binary
    assign upper_bits = {1'b0, work_q[DATA_W-1:1]};
    assign nbr_slice  = upper_bits[slice_base +: SLICE_W];
    assign b2g_slice  = cur_slice ^ nbr_slice;

    assign g2b_advance = step.step && (step.mode == MODE_G2B);

    g2b_chain u_g2b_chain (
        .clk     (clk),
        .rst     (rst),
        .clear   (step.load),
        .advance (g2b_advance),
        .gray_in (cur_slice),
        .bin_out (g2b_slice)
    );

    assign new_slice = (step.mode == MODE_B2G) ? b2g_slice : g2b_slice;

    always_comb begin
        work_next = work_q;
        work_next[slice_base +: SLICE_W] = new_slice;
    end

    always_ff @(posedge clk) begin
        if (step.load) begin
            work_q <= data_in;
        end else if (step.step) begin
            work_q <= work_next;  // write the converted slice back
        end
    end

    // result register holds until the next word completes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= step.last;
            if (step.last) begin
                data_out <= work_next;  // final slice merged in
            end
        end
    end

endmodule

// ==== hw/codec/g2b_chain.sv ====
`timescale 1ns/1ps

module g2b_chain
    import gray_codec_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,
    input  logic   advance,
    input  slice_t gray_in,
    output slice_t bin_out
);

    // binary bit just above the current slice, zero above the word
    logic carry_q;

    // running xor from the top bit of the slice downwards
    always_comb begin
        logic acc;
        acc = carry_q;
        for (int i = SLICE_W - 1; i >= 0; i--) begin
            acc        = acc ^ gray_in[i];
            bin_out[i] = acc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carry_q <= 1'b0;
        end else if (clear) begin
            carry_q <= 1'b0;  // new word starts with nothing above it
        end else if (advance) begin
            carry_q <= bin_out[0];  // seeds the next lower slice
        end
    end

endmodule

// ==== common/codec_step_if.sv ====
`timescale 1ns/1ps

// per-round control from the sequencer to the slice datapath
interface codec_step_if
    import gray_codec_pkg::*;
();

    logic        load;   // capture the input word, one cycle
    logic        step;   // convert and write back one slice
    round_t      round;  // index of the current round
    codec_mode_t mode;   // direction held for the whole conversion
    logic        last;   // final round, result goes out at its end

    modport ctrl (
        output load,
        output step,
        output round,
        output mode,
        output last
    );

    modport dp (
        input load,
        input step,
        input round,
        input mode,
        input last
    );

endinterface

// ==== common/gray_codec_pkg.sv ====
package gray_codec_pkg;

    // word and slice geometry, the whole design is sized from here
    localparam int DATA_W  = 128;
    localparam int SLICE_W = 8;
    localparam int ROUNDS  = DATA_W / SLICE_W;  // one slice per round

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [SLICE_W-1:0] slice_t;
    typedef logic [$clog2(ROUNDS)-1:0] round_t;

    // conversion direction, taken from the mode pin at start
    typedef enum logic {
        MODE_B2G = 1'b0,  // binary in, gray out
        MODE_G2B = 1'b1   // gray in, binary out
    } codec_mode_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } ctrl_state_t;

endpackage
